// File: common/mcd212_pkg.sv
`default_nettype none

package mcd212_pkg;

    // Widths shared by the planes and the mixer
    localparam int CLUT_DEPTH_BITS = 7;
    localparam int WEIGHT_BITS = 6;

    // Register address as issued by a display channel
    typedef logic [6:0] reg_adr_t;

    // One CLUT colour, 6 bits per channel
    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
    } clut_entry_t;

    // Colour that leaves a plane or the mixer
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // Colour layout of a 24-bit register word
    // Each channel sits in the upper 6 bits of its byte
    typedef struct packed {
        logic [5:0] r;
        logic [1:0] pad_r;
        logic [5:0] g;
        logic [1:0] pad_g;
        logic [5:0] b;
        logic [1:0] pad_b;
    } reg_colour_t;

    // The same register word, read as a colour or as control bits
    typedef union packed {
        reg_colour_t colour;
        logic [23:0] raw;
    } reg_word_u;

    // CLUT colours 0 to 63 of the selected bank
    localparam reg_adr_t REG_CLUT_LAST = 7'h3f;

    // Image coding method, plane A in bits 3:0 and plane B in bits 11:8
    localparam reg_adr_t REG_CODING = 7'h40;

    // Bit 0 set puts plane B in front of plane A
    localparam reg_adr_t REG_ORDER = 7'h42;

    // Bank for CLUT writes, 2 bits
    localparam reg_adr_t REG_CLUT_BANK = 7'h43;

    // Transparent colours
    localparam reg_adr_t REG_TRANS_A = 7'h44;
    localparam reg_adr_t REG_TRANS_B = 7'h46;

    // Backdrop in bits 3:0 as y, r, g, b
    localparam reg_adr_t REG_BACKDROP = 7'h58;

    // Weight factors, 6 bits each
    localparam reg_adr_t REG_WEIGHT_A = 7'h5b;
    localparam reg_adr_t REG_WEIGHT_B = 7'h5c;

endpackage

`default_nettype wire

// File: video_plane/clut_memory.sv
`timescale 1ns/10ps
`default_nettype none

module clut_memory #(
    parameter int addr_bits = mcd212_pkg::CLUT_DEPTH_BITS
) (
    input  logic                    clk,
    input  logic                    wr_en,
    input  logic [addr_bits-1:0]    wr_adr,
    input  mcd212_pkg::clut_entry_t wr_data,
    input  logic [addr_bits-1:0]    rd_adr,
    output mcd212_pkg::clut_entry_t rd_data
);
    import mcd212_pkg::*;

    clut_entry_t ram[2**addr_bits];

    // Single clock, one write port and one registered read port
    // A read of the address being written returns the old entry
    always_ff @(posedge clk) begin
        if (wr_en) begin
            ram[wr_adr] <= wr_data;
        end
        rd_data <= ram[rd_adr];
    end

endmodule

`default_nettype wire

// File: video_plane/video_plane.sv
`timescale 1ns/10ps
`default_nettype none

module video_plane #(
    parameter mcd212_pkg::reg_adr_t trans_adr = mcd212_pkg::REG_TRANS_A,
    parameter mcd212_pkg::reg_adr_t weight_adr = mcd212_pkg::REG_WEIGHT_A,
    parameter bit clut_upper = 1'b0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  mcd212_pkg::reg_adr_t  reg_adr,
    input  mcd212_pkg::reg_word_u reg_data,
    input  logic                  reg_write,
    input  logic [7:0]            pixel,
    input  logic                  pixel_strobe,
    input  logic                  new_line,
    output mcd212_pkg::rgb888_t   plane_rgb,
    output logic                  plane_opaque
);
    import mcd212_pkg::*;

    logic                       clut_bank;
    clut_entry_t                trans_colour;
    logic [WEIGHT_BITS-1:0]     weight;
    logic [CLUT_DEPTH_BITS-1:0] held_pixel;

    clut_entry_t                reg_colour;
    logic                       clut_we;
    logic [CLUT_DEPTH_BITS-1:0] clut_wr_adr;
    clut_entry_t                clut_out;

    // Scale a 6-bit level to 8 bits, then apply weight (w + 1) / 64
    function automatic logic [7:0] apply_weight(
        input logic [5:0]             level,
        input logic [WEIGHT_BITS-1:0] w
    );
        logic [14:0] product;
        product = 15'({level, 2'b00}) * (15'(w) + 15'd1);
        // Product stays below 2**14
        return product[13:6];
    endfunction

    // Colour fields picked out of the register word
    assign reg_colour = '{
        r: reg_data.colour.r,
        g: reg_data.colour.g,
        b: reg_data.colour.b
    };

    // CLUT colours 0 to 63 land in the bank given by bank bit 0
    assign clut_we = reg_write && (reg_adr <= REG_CLUT_LAST);
    assign clut_wr_adr = {clut_bank, reg_adr[5:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            clut_bank <= 1'b0;
            trans_colour <= '0;
            weight <= '0;
        end else if (reg_write) begin
            if (reg_adr == REG_CLUT_BANK) begin
                // Bank bit 1 only tells which plane owns the bank
                clut_bank <= reg_data.raw[0];
            end
            if (reg_adr == trans_adr) begin
                trans_colour <= reg_colour;
            end
            if (reg_adr == weight_adr) begin
                weight <= reg_data.raw[WEIGHT_BITS-1:0];
            end
        end
    end

    // Pixel hold, cleared at the start of each line
    // CLUT7 only looks at the lower 7 bits of the index
    always_ff @(posedge clk) begin
        if (reset) begin
            held_pixel <= '0;
        end else if (new_line) begin
            held_pixel <= '0;
        end else if (pixel_strobe) begin
            held_pixel <= pixel[CLUT_DEPTH_BITS-1:0];
        end
    end

    clut_memory #(
        .addr_bits(CLUT_DEPTH_BITS)
    ) clut (
        .clk    (clk),
        .wr_en  (clut_we),
        .wr_adr (clut_wr_adr),
        .wr_data(reg_colour),
        .rd_adr (held_pixel),
        .rd_data(clut_out)
    );

    assign plane_rgb.r = apply_weight(clut_out.r, weight);
    assign plane_rgb.g = apply_weight(clut_out.g, weight);
    assign plane_rgb.b = apply_weight(clut_out.b, weight);

    assign plane_opaque = (clut_out != trans_colour);

    // Plane A may only select banks 0-1, plane B only banks 2-3
    bank_owner_check: assert property (
        @(posedge clk) disable iff (reset)
        (reg_write && reg_adr == REG_CLUT_BANK) |-> (reg_data.raw[1] == clut_upper)
    ) else $error("CLUT bank outside of this plane");

    // The channels stay quiet while the chip is in reset
    no_clut_write_in_reset: assert property (
        @(posedge clk) reset |-> !clut_we
    ) else $error("CLUT write during reset");

endmodule

`default_nettype wire

// File: hdl/plane_mixer.sv
`timescale 1ns/10ps
`default_nettype none

module plane_mixer (
    input  logic                  clk,
    input  logic                  reset,
    input  mcd212_pkg::reg_adr_t  reg_adr,
    input  mcd212_pkg::reg_word_u reg_data,
    input  logic                  reg_write,
    input  mcd212_pkg::rgb888_t   a_rgb,
    input  logic                  a_opaque,
    input  mcd212_pkg::rgb888_t   b_rgb,
    input  logic                  b_opaque,
    output logic [7:0]            r,
    output logic [7:0]            g,
    output logic [7:0]            b
);
    import mcd212_pkg::*;

    logic [3:0] coding_a;
    logic [3:0] coding_b;
    logic       b_in_front;
    logic [3:0] backdrop;

    logic    a_visible;
    logic    b_visible;
    rgb888_t backdrop_rgb;
    rgb888_t mix_rgb;
    rgb888_t out_rgb;

    // Mixing registers, all written by channel 0
    always_ff @(posedge clk) begin
        if (reset) begin
            coding_a <= '0;
            coding_b <= '0;
            b_in_front <= 1'b0;
            backdrop <= '0;
        end else if (reg_write) begin
            case (reg_adr)
                REG_CODING: begin
                    coding_a <= reg_data.raw[3:0];
                    coding_b <= reg_data.raw[11:8];
                end
                REG_ORDER: begin
                    b_in_front <= reg_data.raw[0];
                end
                REG_BACKDROP: begin
                    backdrop <= reg_data.raw[3:0];
                end
                default: begin
                end
            endcase
        end
    end

    // A zero coding method turns the plane off
    assign a_visible = a_opaque && (coding_a != 4'd0);
    assign b_visible = b_opaque && (coding_b != 4'd0);

    // Backdrop bits are y, r, g, b from the top
    // Without y the MSB drops out for half brightness
    assign backdrop_rgb.r = {backdrop[3] & backdrop[2], {7{backdrop[2]}}};
    assign backdrop_rgb.g = {backdrop[3] & backdrop[1], {7{backdrop[1]}}};
    assign backdrop_rgb.b = {backdrop[3] & backdrop[0], {7{backdrop[0]}}};

    // Back plane first, so the front plane overrides it
    always_comb begin
        mix_rgb = backdrop_rgb;
        if (b_in_front) begin
            if (a_visible) begin
                mix_rgb = a_rgb;
            end
            if (b_visible) begin
                mix_rgb = b_rgb;
            end
        end else begin
            if (b_visible) begin
                mix_rgb = b_rgb;
            end
            if (a_visible) begin
                mix_rgb = a_rgb;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_rgb <= '0;
        end else begin
            out_rgb <= mix_rgb;
        end
    end

    assign r = out_rgb.r;
    assign g = out_rgb.g;
    assign b = out_rgb.b;

    // Covers CLUT contents and plane inputs that were never written
    rgb_known_check: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(out_rgb)
    ) else $error("Unknown RGB output");

endmodule

`default_nettype wire

// File: hdl/mcd212_video.sv
`timescale 1ns/10ps
`default_nettype none

module mcd212_video (
    input  logic                  clk,
    input  logic                  reset,
    input  mcd212_pkg::reg_adr_t  ch0_reg_adr,
    input  mcd212_pkg::reg_word_u ch0_reg_data,
    input  logic                  ch0_reg_write,
    input  mcd212_pkg::reg_adr_t  ch1_reg_adr,
    input  mcd212_pkg::reg_word_u ch1_reg_data,
    input  logic                  ch1_reg_write,
    input  logic [7:0]            pixel_a,
    input  logic [7:0]            pixel_b,
    input  logic                  pixel_strobe,
    input  logic                  new_line,
    output logic [7:0]            r,
    output logic [7:0]            g,
    output logic [7:0]            b
);
    import mcd212_pkg::*;

    rgb888_t plane_a_rgb;
    logic    plane_a_opaque;
    rgb888_t plane_b_rgb;
    logic    plane_b_opaque;

    // Plane A on channel 0, CLUT banks 0-1
    video_plane #(
        .trans_adr (REG_TRANS_A),
        .weight_adr(REG_WEIGHT_A),
        .clut_upper(1'b0)
    ) plane_a (
        .clk         (clk),
        .reset       (reset),
        .reg_adr     (ch0_reg_adr),
        .reg_data    (ch0_reg_data),
        .reg_write   (ch0_reg_write),
        .pixel       (pixel_a),
        .pixel_strobe(pixel_strobe),
        .new_line    (new_line),
        .plane_rgb   (plane_a_rgb),
        .plane_opaque(plane_a_opaque)
    );

    // Plane B on channel 1, CLUT banks 2-3
    video_plane #(
        .trans_adr (REG_TRANS_B),
        .weight_adr(REG_WEIGHT_B),
        .clut_upper(1'b1)
    ) plane_b (
        .clk         (clk),
        .reset       (reset),
        .reg_adr     (ch1_reg_adr),
        .reg_data    (ch1_reg_data),
        .reg_write   (ch1_reg_write),
        .pixel       (pixel_b),
        .pixel_strobe(pixel_strobe),
        .new_line    (new_line),
        .plane_rgb   (plane_b_rgb),
        .plane_opaque(plane_b_opaque)
    );

    // Coding, order and backdrop are only reachable from channel 0
    plane_mixer mixer (
        .clk      (clk),
        .reset    (reset),
        .reg_adr  (ch0_reg_adr),
        .reg_data (ch0_reg_data),
        .reg_write(ch0_reg_write),
        .a_rgb    (plane_a_rgb),
        .a_opaque (plane_a_opaque),
        .b_rgb    (plane_b_rgb),
        .b_opaque (plane_b_opaque),
        .r        (r),
        .g        (g),
        .b        (b)
    );

endmodule

`default_nettype wire

// File: dv/mcd212_video_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mcd212_video_tb;
    import mcd212_pkg::*;

    localparam int CLK_HALF = 20;
    localparam int RESET_CYCLES = 8;
    localparam int PIPE_CYCLES = 3;
    localparam int RUN_LIMIT = 20000;

    logic       clk;
    logic       reset;
    reg_adr_t   ch0_reg_adr;
    reg_word_u  ch0_reg_data;
    logic       ch0_reg_write;
    reg_adr_t   ch1_reg_adr;
    reg_word_u  ch1_reg_data;
    logic       ch1_reg_write;
    logic [7:0] pixel_a;
    logic [7:0] pixel_b;
    logic       pixel_strobe;
    logic       new_line;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;

    integer seed;
    int     errors;
    int     checks;
    bit     run_done;

    // Reference state, updated from the register rules
    clut_entry_t      clut_a[128];
    clut_entry_t      clut_b[128];
    logic [1:0]       bank_a;
    logic [1:0]       bank_b;
    clut_entry_t      trans_a;
    clut_entry_t      trans_b;
    logic [5:0]       weight_a;
    logic [5:0]       weight_b;
    logic [3:0]       coding_a;
    logic [3:0]       coding_b;
    logic             order_b;
    logic [3:0]       backdrop;
    logic [6:0]       held_a;
    logic [6:0]       held_b;

    mcd212_video dut (
        .clk          (clk),
        .reset        (reset),
        .ch0_reg_adr  (ch0_reg_adr),
        .ch0_reg_data (ch0_reg_data),
        .ch0_reg_write(ch0_reg_write),
        .ch1_reg_adr  (ch1_reg_adr),
        .ch1_reg_data (ch1_reg_data),
        .ch1_reg_write(ch1_reg_write),
        .pixel_a      (pixel_a),
        .pixel_b      (pixel_b),
        .pixel_strobe (pixel_strobe),
        .new_line     (new_line),
        .r            (r),
        .g            (g),
        .b            (b)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Guards against a stuck run
    initial begin
        int cycles;
        cycles = 0;
        while (!run_done && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!run_done) begin
            $display("Timeout: the run did not finish within %0d clock cycles", RUN_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic wait_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
        end
    endtask

    function automatic clut_entry_t rand_colour();
        logic [31:0] value;
        value = $random(seed);
        return value[17:0];
    endfunction

    // Pad bits get random values that the planes ignore
    function automatic reg_word_u colour_word(input clut_entry_t c);
        reg_word_u w;
        w.raw = $random(seed);
        w.colour.r = c.r;
        w.colour.g = c.g;
        w.colour.b = c.b;
        return w;
    endfunction

    // Colour view of a register word without its pad bits
    function automatic clut_entry_t entry_of_word(input reg_word_u w);
        clut_entry_t c;
        c.r = w.colour.r;
        c.g = w.colour.g;
        c.b = w.colour.b;
        return c;
    endfunction

    function automatic reg_word_u control_word(input logic [23:0] value);
        reg_word_u w;
        w.raw = value;
        return w;
    endfunction

    // 6-bit level to 8 bits, times (weight + 1) / 64
    function automatic logic [7:0] weighted(input logic [5:0] level, input logic [5:0] w);
        int scaled;
        scaled = (int'(level) * 4 * (int'(w) + 1)) / 64;
        return scaled[7:0];
    endfunction

    function automatic logic [7:0] backdrop_level(input logic on);
        if (!on) begin
            return 8'h00;
        end
        return backdrop[3] ? 8'hff : 8'h7f;
    endfunction

    function automatic rgb888_t expected_rgb();
        clut_entry_t ea;
        clut_entry_t eb;
        logic        a_shown;
        logic        b_shown;
        rgb888_t     result;
        ea = clut_a[held_a];
        eb = clut_b[held_b];
        a_shown = (ea != trans_a) && (coding_a != 4'd0);
        b_shown = (eb != trans_b) && (coding_b != 4'd0);
        if (a_shown && (!order_b || !b_shown)) begin
            result.r = weighted(ea.r, weight_a);
            result.g = weighted(ea.g, weight_a);
            result.b = weighted(ea.b, weight_a);
        end else if (b_shown) begin
            result.r = weighted(eb.r, weight_b);
            result.g = weighted(eb.g, weight_b);
            result.b = weighted(eb.b, weight_b);
        end else begin
            result.r = backdrop_level(backdrop[2]);
            result.g = backdrop_level(backdrop[1]);
            result.b = backdrop_level(backdrop[0]);
        end
        return result;
    endfunction

    task automatic check_rgb(input string label, input rgb888_t actual, input rgb888_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED {r,g,b} in %s: actual 0x%06h, expected 0x%06h",
                     label, actual, expected);
        end
    endtask

    task automatic compare_output(input string label);
        rgb888_t actual;
        actual = {r, g, b};
        check_rgb(label, actual, expected_rgb());
    endtask

    // One register write, then the matching reference update
    task automatic write_reg(input bit ch, input reg_adr_t adr, input reg_word_u word);
        if (ch == 1'b0) begin
            ch0_reg_adr = adr;
            ch0_reg_data = word;
            ch0_reg_write = 1'b1;
        end else begin
            ch1_reg_adr = adr;
            ch1_reg_data = word;
            ch1_reg_write = 1'b1;
        end
        @(posedge clk);
        @(negedge clk);
        ch0_reg_write = 1'b0;
        ch1_reg_write = 1'b0;
        if (adr <= REG_CLUT_LAST) begin
            if (ch == 1'b0) begin
                clut_a[{bank_a[0], adr[5:0]}] = entry_of_word(word);
            end else begin
                clut_b[{bank_b[0], adr[5:0]}] = entry_of_word(word);
            end
        end else if (adr == REG_CLUT_BANK) begin
            if (ch == 1'b0) begin
                bank_a = word.raw[1:0];
            end else begin
                bank_b = word.raw[1:0];
            end
        end else if (ch == 1'b0) begin
            case (adr)
                REG_TRANS_A: trans_a = entry_of_word(word);
                REG_WEIGHT_A: weight_a = word.raw[5:0];
                REG_CODING: begin
                    coding_a = word.raw[3:0];
                    coding_b = word.raw[11:8];
                end
                REG_ORDER: order_b = word.raw[0];
                REG_BACKDROP: backdrop = word.raw[3:0];
                default: begin
                end
            endcase
        end else begin
            if (adr == REG_TRANS_B) begin
                trans_b = entry_of_word(word);
            end
            if (adr == REG_WEIGHT_B) begin
                weight_b = word.raw[5:0];
            end
        end
    endtask

    // Strobe one pixel pair and wait until it reaches the output
    task automatic show_pixels(input logic [7:0] pa, input logic [7:0] pb);
        pixel_a = pa;
        pixel_b = pb;
        pixel_strobe = 1'b1;
        @(posedge clk);
        @(negedge clk);
        pixel_strobe = 1'b0;
        held_a = pa[6:0];
        held_b = pb[6:0];
        wait_cycles(PIPE_CYCLES);
    endtask

    task automatic run_random_pixels(input string label, input int count);
        for (int i = 0; i < count; i++) begin
            show_pixels(8'($random(seed)), 8'($random(seed)));
            compare_output(label);
        end
    endtask

    task automatic reset_output_zero();
        rgb888_t actual;
        for (int i = 0; i < 4; i++) begin
            show_pixels(8'($random(seed)), 8'($random(seed)));
            actual = {r, g, b};
            check_rgb("reset output", actual, 24'h000000);
        end
    endtask

    task automatic all_backdrops();
        for (int bd = 0; bd < 16; bd++) begin
            write_reg(1'b0, REG_BACKDROP, control_word(24'(bd)));
            run_random_pixels("backdrop", 1);
        end
    endtask

    task automatic load_cluts();
        for (int bank = 0; bank < 2; bank++) begin
            write_reg(1'b0, REG_CLUT_BANK, control_word(24'(bank)));
            write_reg(1'b1, REG_CLUT_BANK, control_word(24'(bank + 2)));
            for (int i = 0; i < 64; i++) begin
                write_reg(1'b0, reg_adr_t'(i), colour_word(rand_colour()));
                write_reg(1'b1, reg_adr_t'(i), colour_word(rand_colour()));
            end
        end
    endtask

    task automatic clut_and_weight();
        logic [5:0] wa;
        logic [5:0] wb;
        load_cluts();
        write_reg(1'b0, REG_TRANS_A, colour_word(rand_colour()));
        write_reg(1'b1, REG_TRANS_B, colour_word(rand_colour()));
        write_reg(1'b0, REG_CODING, control_word(24'h000504));
        for (int k = 0; k < 4; k++) begin
            wa = (k == 0) ? 6'd0 : (k == 1) ? 6'd63 : 6'($random(seed));
            wb = (k == 0) ? 6'd63 : (k == 1) ? 6'd0 : 6'($random(seed));
            write_reg(1'b0, REG_WEIGHT_A, control_word(24'(wa)));
            write_reg(1'b1, REG_WEIGHT_B, control_word(24'(wb)));
            for (int ord = 0; ord < 2; ord++) begin
                write_reg(1'b0, REG_ORDER, control_word(24'(ord)));
                run_random_pixels("clut and weight", 6);
            end
        end
    endtask

    task automatic transparency();
        logic [6:0] ia;
        logic [6:0] ib;
        ia = 7'($random(seed));
        ib = 7'($random(seed));
        write_reg(1'b0, REG_ORDER, control_word(24'h0));
        write_reg(1'b0, REG_BACKDROP, control_word(24'hd));
        write_reg(1'b1, REG_TRANS_B, colour_word(~clut_b[ib]));
        // Plane A see-through with plane B behind it
        write_reg(1'b0, REG_TRANS_A, colour_word(clut_a[ia]));
        show_pixels({1'b0, ia}, {1'b1, ib});
        compare_output("transparent A over B");
        // Nothing left but the backdrop
        write_reg(1'b1, REG_TRANS_B, colour_word(clut_b[ib]));
        show_pixels({1'b0, ia}, {1'b0, ib});
        compare_output("transparent A and B");
        write_reg(1'b0, REG_ORDER, control_word(24'h1));
        write_reg(1'b0, REG_TRANS_A, colour_word(~clut_a[ia]));
        show_pixels({1'b1, ia}, {1'b0, ib});
        compare_output("transparent B over A");
    endtask

    task automatic plane_order();
        logic [6:0] ia;
        logic [6:0] ib;
        ia = 7'($random(seed));
        ib = 7'($random(seed));
        write_reg(1'b0, REG_TRANS_A, colour_word(~clut_a[ia]));
        write_reg(1'b1, REG_TRANS_B, colour_word(~clut_b[ib]));
        write_reg(1'b0, REG_CODING, control_word(24'h000201));
        write_reg(1'b0, REG_ORDER, control_word(24'h0));
        show_pixels({1'b0, ia}, {1'b0, ib});
        compare_output("order A in front");
        write_reg(1'b0, REG_ORDER, control_word(24'h1));
        show_pixels({1'b0, ia}, {1'b0, ib});
        compare_output("order B in front");
        // B in front but switched off
        write_reg(1'b0, REG_CODING, control_word(24'h000003));
        show_pixels({1'b0, ia}, {1'b0, ib});
        compare_output("coding B zero");
        write_reg(1'b0, REG_ORDER, control_word(24'h0));
        write_reg(1'b0, REG_CODING, control_word(24'h000200));
        show_pixels({1'b0, ia}, {1'b0, ib});
        compare_output("coding A zero");
        write_reg(1'b0, REG_CODING, control_word(24'h000201));
    endtask

    task automatic pixel_hold();
        write_reg(1'b0, REG_TRANS_A, colour_word(~clut_a[0]));
        write_reg(1'b1, REG_TRANS_B, colour_word(~clut_b[0]));
        show_pixels(8'($random(seed)) | 8'h01, 8'($random(seed)) | 8'h01);
        compare_output("pixel held");
        // Inputs move, but without a strobe nothing is taken
        for (int i = 0; i < 5; i++) begin
            pixel_a = 8'($random(seed));
            pixel_b = 8'($random(seed));
            @(negedge clk);
            compare_output("pixel held without strobe");
        end
        new_line = 1'b1;
        @(posedge clk);
        @(negedge clk);
        new_line = 1'b0;
        held_a = 7'd0;
        held_b = 7'd0;
        wait_cycles(PIPE_CYCLES);
        compare_output("new line");
    endtask

    initial begin
        seed = 32'hf721_70f1;
        errors = 0;
        checks = 0;
        run_done = 1'b0;
        reset = 1'b1;
        ch0_reg_adr = '0;
        ch0_reg_data = '0;
        ch0_reg_write = 1'b0;
        ch1_reg_adr = '0;
        ch1_reg_data = '0;
        ch1_reg_write = 1'b0;
        pixel_a = '0;
        pixel_b = '0;
        pixel_strobe = 1'b0;
        new_line = 1'b0;
        for (int i = 0; i < 128; i++) begin
            clut_a[i] = '0;
            clut_b[i] = '0;
        end
        {bank_a, bank_b, trans_a, trans_b, weight_a, weight_b} = '0;
        {coding_a, coding_b, order_b, backdrop, held_a, held_b} = '0;

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        reset = 1'b0;

        reset_output_zero();
        all_backdrops();
        clut_and_weight();
        transparency();
        plane_order();
        pixel_hold();

        run_done = 1'b1;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
common/mcd212_pkg.sv
video_plane/clut_memory.sv
video_plane/video_plane.sv
hdl/plane_mixer.sv
hdl/mcd212_video.sv
dv/mcd212_video_tb.sv
